// File: flist.f
src/ldp_cfg_pkg.sv
src/ldp_axi_pkg.sv
src/ldp_md_capture.sv
src/ldp_addr_gen.sv
src/ldp_aw_ctrl.sv
src/ldp_w_ctrl.sv
src/ldp_top.sv
sim/ldp_checker.sv
sim/tb_ldp.sv

// File: sim/tb_ldp.sv
// Testbench top for the host-RAM frame writer
// Streams frames and metadata into the DUT against a randomly stalling AXI slave

`timescale 1ns/1ps
`default_nettype none

module tb_ldp;

    localparam int DATA_W           = 64;
    localparam int FD_BURST_BEATS   = 4;
    localparam int BURSTS_PER_GROUP = 2;
    localparam int N_FRAMES         = 8;
    localparam int FRAME_BURSTS     = 3;
    localparam int SEED             = 37088;
    // 8 frames of 18 W beats are 144 transfers, the rest is slack for random stalls
    localparam int TIMEOUT_CYCLES   = 4000;

    logic                    clk;
    logic                    resetn;
    ldp_cfg_pkg::ldp_cfg_t   cfg;
    logic [DATA_W-1:0]       fd_tdata;
    logic                    fd_tvalid;
    logic                    fd_tready;
    logic [DATA_W-1:0]       md_tdata;
    logic                    md_tvalid;
    logic                    md_tready;
    ldp_axi_pkg::aw_req_t    aw;
    logic                    aw_ready;
    ldp_axi_pkg::w_beat_t    w;
    logic                    w_ready;
    logic                    start_of_frame;
    logic                    done;
    int                      error_count;
    int                      aw_count;
    int                      w_count;
    logic [31:0]             tags [N_FRAMES];

    ldp_top #(
        .DATA_W           (DATA_W),
        .FD_BURST_BEATS   (FD_BURST_BEATS),
        .BURSTS_PER_GROUP (BURSTS_PER_GROUP)
    ) ldp_top_i (
        .clk            (clk),
        .resetn         (resetn),
        .cfg            (cfg),
        .fd_tdata       (fd_tdata),
        .fd_tvalid      (fd_tvalid),
        .fd_tready      (fd_tready),
        .md_tdata       (md_tdata),
        .md_tvalid      (md_tvalid),
        .md_tready      (md_tready),
        .aw             (aw),
        .aw_ready       (aw_ready),
        .w              (w),
        .w_ready        (w_ready),
        .start_of_frame (start_of_frame)
    );

    ldp_checker #(
        .DATA_W           (DATA_W),
        .FD_BURST_BEATS   (FD_BURST_BEATS),
        .BURSTS_PER_GROUP (BURSTS_PER_GROUP),
        .N_FRAMES         (N_FRAMES)
    ) ldp_checker_i (
        .clk            (clk),
        .resetn         (resetn),
        .cfg            (cfg),
        .fd_tvalid      (fd_tvalid),
        .fd_tready      (fd_tready),
        .md_tdata       (md_tdata),
        .md_tvalid      (md_tvalid),
        .md_tready      (md_tready),
        .aw             (aw),
        .aw_ready       (aw_ready),
        .w              (w),
        .w_ready        (w_ready),
        .start_of_frame (start_of_frame),
        .done           (done),
        .error_count    (error_count),
        .aw_count       (aw_count),
        .w_count        (w_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ========================================
    // Slave back-pressure
    // ========================================
    initial begin : slave_ready
        int unused;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        unused   = $urandom(SEED);
        // Metadata tags come from the same seeded sequence
        foreach (tags[i]) tags[i] = $urandom;
        forever begin
            @(posedge clk);
            #1;
            aw_ready = ($urandom % 4) != 0;
            w_ready  = ($urandom % 4) != 0;
        end
    end

    // Frame data is a running beat index, held until the DUT takes it
    initial begin : fd_stream
        fd_tvalid = 1'b0;
        fd_tdata  = '0;
        wait (resetn === 1'b1);
        @(posedge clk);
        for (int i = 0; i < N_FRAMES * FRAME_BURSTS * FD_BURST_BEATS; i++) begin
            #1;
            fd_tvalid = 1'b1;
            fd_tdata  = i;
            @(posedge clk);
            while (!fd_tready) @(posedge clk);
        end
        #1;
        fd_tvalid = 1'b0;
    end

    // Two metadata beats per frame, offered once the frame's first beat is taken
    initial begin : md_stream
        md_tvalid = 1'b0;
        md_tdata  = '0;
        for (int f = 0; f < N_FRAMES; f++) begin
            @(posedge clk);
            while (!(start_of_frame && w_ready)) @(posedge clk);
            for (int b = 0; b < ldp_axi_pkg::MD_BEATS; b++) begin
                #1;
                md_tvalid = 1'b1;
                md_tdata  = (b == 0) ? {32'(f + 1), tags[f]} : {~tags[f], 32'(f + 1)};
                @(posedge clk);
                while (!md_tready) @(posedge clk);
            end
            #1;
            md_tvalid = 1'b0;
        end
    end

    // ========================================
    // Configuration, reset and end of run
    // ========================================
    initial begin : run_control
        int cycles;
        cfg              = '0;
        cfg.frame_bursts = 32'(FRAME_BURSTS);
        cfg.fd0_base     = 64'h0000_0001_0000_0000;
        cfg.fd1_base     = 64'h0000_0002_0000_0000;
        // Five bursts of 32 bytes, so both rings wrap during the run
        cfg.fd_ring_size = 64'd160;
        cfg.md0_base     = 64'h0000_0003_0000_0000;
        cfg.md1_base     = 64'h0000_0003_1000_0000;
        cfg.md_ring_size = 64'd48;
        cfg.fc0_addr     = 64'h0000_0004_0000_0000;
        cfg.fc1_addr     = 64'h0000_0004_0000_0040;
        resetn = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        resetn = 1'b1;
        cycles = 0;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            $display("Timeout after %0d cycles, the frames did not all complete", cycles);
        end
        $display("Errors: %0d, AW requests: %0d, W beats: %0d, cycles: %0d",
                 error_count, aw_count, w_count, cycles);
        if (!done || error_count != 0) begin
            $display("Test failures found");
        end else begin
            $display("All tests passed!");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/ldp_checker.sv
// Scoreboard for the frame writer testbench
// Watches the DUT ports, predicts every AW and W transfer and reports mismatches

`timescale 1ns/1ps
`default_nettype none

module ldp_checker #(
    parameter int DATA_W           = 64,
    parameter int FD_BURST_BEATS   = 4,
    parameter int BURSTS_PER_GROUP = 2,
    parameter int N_FRAMES         = 8
) (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire ldp_cfg_pkg::ldp_cfg_t  cfg,
    input  wire                         fd_tvalid,
    input  wire                         fd_tready,
    input  wire [DATA_W-1:0]            md_tdata,
    input  wire                         md_tvalid,
    input  wire                         md_tready,
    input  wire ldp_axi_pkg::aw_req_t   aw,
    input  wire                         aw_ready,
    input  wire ldp_axi_pkg::w_beat_t   w,
    input  wire                         w_ready,
    input  wire                         start_of_frame,
    output logic                        done,
    output int                          error_count,
    output int                          aw_count,
    output int                          w_count
);

    localparam int FD_BYTES = FD_BURST_BEATS * (DATA_W / 8);
    localparam int MD_BYTES = ldp_axi_pkg::MD_BEATS * (DATA_W / 8);

    // Metadata beats in the order the DUT accepted them with two per frame
    logic [DATA_W-1:0]    md_q [$];
    ldp_axi_pkg::aw_req_t aw_exp;
    ldp_axi_pkg::w_beat_t w_exp;
    logic                 sof_exp;
    int                   frames_started = 0;
    int                   aw_per_frame;
    int                   w_per_frame;
    bit                   fd_seen = 1'b0;

    // Each frame has its frame-data bursts, two metadata bursts and two counter writes
    assign aw_per_frame = int'(cfg.frame_bursts) + 4;
    assign w_per_frame  = int'(cfg.frame_bursts) * FD_BURST_BEATS + 6;
    assign done = (aw_count == N_FRAMES * aw_per_frame) && (w_count == N_FRAMES * w_per_frame);

    initial begin
        error_count = 0;
        aw_count    = 0;
        w_count     = 0;
    end

    // ========================================
    // Reference model
    // ========================================

    // Expected k-th write-address request of the run
    function automatic ldp_axi_pkg::aw_req_t aw_request_at(input int k);
        ldp_axi_pkg::aw_req_t r;
        ldp_cfg_pkg::host_addr_t off;
        int fb;
        int f;
        int j;
        int g;
        int n;
        fb = int'(cfg.frame_bursts);
        f  = k / (fb + 4);
        j  = k % (fb + 4);
        r  = '0;
        r.valid = 1'b1;
        if (j < fb) begin
            // Groups of bursts alternate rings and n counts the earlier bursts to this ring
            g   = f * fb + j;
            n   = (g / (2 * BURSTS_PER_GROUP)) * BURSTS_PER_GROUP + g % BURSTS_PER_GROUP;
            off = 64'(n * FD_BYTES) % cfg.fd_ring_size;
            r.addr = (((g / BURSTS_PER_GROUP) % 2) == 1) ? cfg.fd1_base + off
                                                         : cfg.fd0_base + off;
            r.len  = 8'(FD_BURST_BEATS - 1);
        end else if (j < fb + 2) begin
            off    = 64'(f * MD_BYTES) % cfg.md_ring_size;
            r.addr = (j == fb) ? cfg.md0_base + off : cfg.md1_base + off;
            r.len  = 8'(ldp_axi_pkg::MD_BEATS - 1);
        end else begin
            r.addr = (j == fb + 2) ? cfg.fc0_addr : cfg.fc1_addr;
        end
        return r;
    endfunction

    // Expected k-th write-data beat with only the low bus bits filled
    function automatic ldp_axi_pkg::w_beat_t w_beat_at(input int k);
        ldp_axi_pkg::w_beat_t r;
        int fd_beats;
        int f;
        int j;
        int m;
        fd_beats = int'(cfg.frame_bursts) * FD_BURST_BEATS;
        f = k / (fd_beats + 6);
        j = k % (fd_beats + 6);
        r = '0;
        r.valid = 1'b1;
        r.last  = 1'b1;
        if (j < fd_beats) begin
            // The stream carries a running beat index across all frames
            r.data[DATA_W-1:0]   = f * fd_beats + j;
            r.strb[DATA_W/8-1:0] = '1;
            r.last = ((j % FD_BURST_BEATS) == FD_BURST_BEATS - 1);
        end else if (j < fd_beats + 4) begin
            m = 2 * f + (j - fd_beats) % 2;
            if (m < md_q.size()) begin
                r.data[DATA_W-1:0] = md_q[m];
            end
            r.strb[DATA_W/8-1:0] = '1;
            r.last = (((j - fd_beats) % 2) == 1);
        end else begin
            r.data[31:0] = 32'(f + 1);
            r.strb[3:0]  = 4'hf;
        end
        return r;
    endfunction

    task automatic flag_mismatch(input string name, input logic [63:0] exp_val,
                                 input logic [63:0] got_val);
        $display("** Error at %0t: %s expected %h, got %h", $time, name, exp_val, got_val);
        error_count++;
    endtask

    task automatic note_failure(input string msg);
        $display("Error at %0t: %s", $time, msg);
        error_count++;
    endtask

    // ========================================
    // Transfer monitor
    // ========================================
    always @(posedge clk) begin
        // Nothing may be requested before the stream has delivered a beat
        if ((!resetn || !fd_seen) && (aw.valid || md_tready)) begin
            note_failure("aw.valid or md_tready went high before the first stream beat");
        end
        if (resetn && fd_tvalid && fd_tready) begin
            fd_seen = 1'b1;
        end
        if (resetn && md_tvalid && md_tready) begin
            md_q.push_back(md_tdata);
        end
        if (resetn && aw.valid && aw_ready) begin
            if (aw_count >= N_FRAMES * aw_per_frame) begin
                note_failure("AW request seen after the last expected frame");
            end else begin
                aw_exp = aw_request_at(aw_count);
                if (aw.addr !== aw_exp.addr) flag_mismatch("aw.addr", aw_exp.addr, aw.addr);
                if (aw.len !== aw_exp.len) flag_mismatch("aw.len", aw_exp.len, aw.len);
                // A frame's first request must trail its first data beat
                if ((aw_count % aw_per_frame) == 0 &&
                    frames_started <= aw_count / aw_per_frame) begin
                    note_failure("first frame-data AW request came before its frame started");
                end
            end
            aw_count++;
        end
        if (resetn && w.valid && w_ready) begin
            if (w_count >= N_FRAMES * w_per_frame) begin
                note_failure("W beat seen after the last expected frame");
            end else begin
                w_exp = w_beat_at(w_count);
                if (w.data[DATA_W-1:0] !== w_exp.data[DATA_W-1:0]) begin
                    flag_mismatch("w.data", w_exp.data[DATA_W-1:0], w.data[DATA_W-1:0]);
                end
                if (w.strb[DATA_W/8-1:0] !== w_exp.strb[DATA_W/8-1:0]) begin
                    flag_mismatch("w.strb", w_exp.strb[DATA_W/8-1:0], w.strb[DATA_W/8-1:0]);
                end
                if (w.last !== w_exp.last) flag_mismatch("w.last", w_exp.last, w.last);
                // Only the first beat of each frame is marked as its start
                sof_exp = ((w_count % w_per_frame) == 0);
                if (start_of_frame !== sof_exp) begin
                    flag_mismatch("start_of_frame", sof_exp, start_of_frame);
                end
            end
            if (start_of_frame) begin
                frames_started++;
            end
            w_count++;
        end
    end

endmodule

`default_nettype wire

// File: src/ldp_top.sv
// Top level of the host-RAM frame writer
// Joins metadata capture, address pointers and the AW and W sequencers

`timescale 1ns/1ps
`default_nettype none

module ldp_top #(
    parameter int DATA_W           = 512,
    parameter int FD_BURST_BEATS   = 64,
    parameter int BURSTS_PER_GROUP = 4
) (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire ldp_cfg_pkg::ldp_cfg_t  cfg,
    // Frame-data stream
    input  wire [DATA_W-1:0]            fd_tdata,
    input  wire                         fd_tvalid,
    output logic                        fd_tready,
    // Metadata stream
    input  wire [DATA_W-1:0]            md_tdata,
    input  wire                         md_tvalid,
    output logic                        md_tready,
    // AXI4 write address and write data
    output ldp_axi_pkg::aw_req_t        aw,
    input  wire                         aw_ready,
    output ldp_axi_pkg::w_beat_t        w,
    input  wire                         w_ready,
    output logic                        start_of_frame
);

    logic                                       frame_start;
    logic [31:0]                                frame_count;
    logic [ldp_axi_pkg::MD_BEATS-1:0][DATA_W-1:0] md_words;
    logic                                       fd_adv;
    logic                                       md_adv;
    ldp_cfg_pkg::host_addr_t                    fd_addr;
    ldp_cfg_pkg::host_addr_t                    md0_addr;
    ldp_cfg_pkg::host_addr_t                    md1_addr;

    ldp_md_capture #(.DATA_W(DATA_W)) ldp_md_capture_i (
        .clk         (clk),
        .resetn      (resetn),
        .frame_start (frame_start),
        .md_tdata    (md_tdata),
        .md_tvalid   (md_tvalid),
        .md_tready   (md_tready),
        .md_words    (md_words)
    );

    ldp_addr_gen #(
        .DATA_W           (DATA_W),
        .FD_BURST_BEATS   (FD_BURST_BEATS),
        .BURSTS_PER_GROUP (BURSTS_PER_GROUP)
    ) ldp_addr_gen_i (
        .clk      (clk),
        .resetn   (resetn),
        .cfg      (cfg),
        .fd_adv   (fd_adv),
        .md_adv   (md_adv),
        .fd_addr  (fd_addr),
        .md0_addr (md0_addr),
        .md1_addr (md1_addr)
    );

    // AW may run several bursts ahead of W within a frame
    ldp_aw_ctrl #(.FD_BURST_BEATS(FD_BURST_BEATS)) ldp_aw_ctrl_i (
        .clk         (clk),
        .resetn      (resetn),
        .cfg         (cfg),
        .frame_count (frame_count),
        .fd_addr     (fd_addr),
        .md0_addr    (md0_addr),
        .md1_addr    (md1_addr),
        .aw_ready    (aw_ready),
        .aw          (aw),
        .fd_adv      (fd_adv),
        .md_adv      (md_adv)
    );

    ldp_w_ctrl #(
        .DATA_W         (DATA_W),
        .FD_BURST_BEATS (FD_BURST_BEATS)
    ) ldp_w_ctrl_i (
        .clk            (clk),
        .resetn         (resetn),
        .cfg            (cfg),
        .fd_tdata       (fd_tdata),
        .fd_tvalid      (fd_tvalid),
        .fd_tready      (fd_tready),
        .md_words       (md_words),
        .w_ready        (w_ready),
        .w              (w),
        .frame_start    (frame_start),
        .start_of_frame (start_of_frame),
        .frame_count    (frame_count)
    );

endmodule

`default_nettype wire

// File: src/ldp_w_ctrl.sv
// Write-data sequencer for the frame writer
// Passes frame data straight to W, then sends metadata and the frame count

`timescale 1ns/1ps
`default_nettype none

module ldp_w_ctrl #(
    parameter int DATA_W         = 512,
    parameter int FD_BURST_BEATS = 64
) (
    input  wire                             clk,
    input  wire                             resetn,
    input  wire ldp_cfg_pkg::ldp_cfg_t      cfg,
    input  wire [DATA_W-1:0]                fd_tdata,
    input  wire                             fd_tvalid,
    output logic                            fd_tready,
    input  wire [ldp_axi_pkg::MD_BEATS-1:0][DATA_W-1:0] md_words,
    input  wire                             w_ready,
    output ldp_axi_pkg::w_beat_t            w,
    output logic                            frame_start,
    output logic                            start_of_frame,
    output logic [31:0]                     frame_count
);

    ldp_axi_pkg::w_state_t state;

    // 0-based beat within the current burst
    logic [7:0]  beat_cnt;
    // 0-based burst within the current frame
    logic [31:0] burst_cnt;
    logic        w_xfer;

    assign w_xfer         = w.valid & w_ready;
    assign start_of_frame = (state == ldp_axi_pkg::W_FIRST_FD) & fd_tvalid;
    assign frame_start    = start_of_frame & w_ready;

    always_comb begin
        w         = '0;
        fd_tready = 1'b0;
        case (state)
            ldp_axi_pkg::W_FIRST_FD, ldp_axi_pkg::W_FD: begin
                // Zero-latency pass-through where the slave stalls the stream directly
                fd_tready               = w_ready;
                w.valid                 = fd_tvalid;
                w.data[DATA_W-1:0]      = fd_tdata;
                w.strb[DATA_W/8-1:0]    = '1;
                w.last                  = (beat_cnt == 8'(FD_BURST_BEATS - 1));
            end
            ldp_axi_pkg::W_MD00, ldp_axi_pkg::W_MD10: begin
                w.valid                 = 1'b1;
                w.data[DATA_W-1:0]      = md_words[0];
                w.strb[DATA_W/8-1:0]    = '1;
            end
            ldp_axi_pkg::W_MD01, ldp_axi_pkg::W_MD11: begin
                w.valid                 = 1'b1;
                w.data[DATA_W-1:0]      = md_words[1];
                w.strb[DATA_W/8-1:0]    = '1;
                w.last                  = 1'b1;
            end
            ldp_axi_pkg::W_FC0, ldp_axi_pkg::W_FC1: begin
                // Frame counter beats write only the low 32 bits
                w.valid                 = 1'b1;
                w.data[31:0]            = frame_count;
                w.strb[3:0]             = 4'hf;
                w.last                  = 1'b1;
            end
            default: begin
                w         = '0;
                fd_tready = 1'b0;
            end
        endcase
    end

    // ========================================
    // Beat sequencing
    // ========================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= ldp_axi_pkg::W_FIRST_FD;
            beat_cnt    <= 8'd0;
            burst_cnt   <= 32'd0;
            frame_count <= 32'd0;
        end else if (w_xfer) begin
            // The count is 1-based, so it already names the frame in flight
            if (frame_start) begin
                frame_count <= frame_count + 32'd1;
            end
            case (state)
                ldp_axi_pkg::W_FIRST_FD, ldp_axi_pkg::W_FD: begin
                    if (w.last) begin
                        beat_cnt <= 8'd0;
                        if (burst_cnt == cfg.frame_bursts - 32'd1) begin
                            burst_cnt <= 32'd0;
                            state     <= ldp_axi_pkg::W_MD00;
                        end else begin
                            burst_cnt <= burst_cnt + 32'd1;
                            state     <= ldp_axi_pkg::W_FD;
                        end
                    end else begin
                        beat_cnt <= beat_cnt + 8'd1;
                        state    <= ldp_axi_pkg::W_FD;
                    end
                end
                ldp_axi_pkg::W_MD00: state <= ldp_axi_pkg::W_MD01;
                ldp_axi_pkg::W_MD01: state <= ldp_axi_pkg::W_MD10;
                ldp_axi_pkg::W_MD10: state <= ldp_axi_pkg::W_MD11;
                ldp_axi_pkg::W_MD11: state <= ldp_axi_pkg::W_FC0;
                ldp_axi_pkg::W_FC0:  state <= ldp_axi_pkg::W_FC1;
                default:             state <= ldp_axi_pkg::W_FIRST_FD;
            endcase
        end
    end

    // Upstream holds its stream idle while the writer is in reset
    assert property (@(posedge clk) !resetn |-> !w.valid)
        else $error("w.valid high during reset");

endmodule

`default_nettype wire

// File: src/ldp_aw_ctrl.sv
// Write-address sequencer for the frame writer
// Issues the frame-data, metadata and frame-counter requests of each frame

`timescale 1ns/1ps
`default_nettype none

module ldp_aw_ctrl #(
    parameter int FD_BURST_BEATS = 64
) (
    input  wire                             clk,
    input  wire                             resetn,
    input  wire ldp_cfg_pkg::ldp_cfg_t      cfg,
    input  wire [31:0]                      frame_count,
    input  wire ldp_cfg_pkg::host_addr_t    fd_addr,
    input  wire ldp_cfg_pkg::host_addr_t    md0_addr,
    input  wire ldp_cfg_pkg::host_addr_t    md1_addr,
    input  wire                             aw_ready,
    output ldp_axi_pkg::aw_req_t            aw,
    output logic                            fd_adv,
    output logic                            md_adv
);

    ldp_axi_pkg::aw_state_t state;

    // Frames whose first request has gone out
    logic [31:0] issued_frames;
    // Frame-data requests issued within the current frame
    logic [31:0] burst_cnt;
    logic        aw_xfer;

    assign aw_xfer = aw.valid & aw_ready;
    assign fd_adv  = aw_xfer & ((state == ldp_axi_pkg::AW_FIRST_FD) |
                                (state == ldp_axi_pkg::AW_FD));
    assign md_adv  = aw_xfer & (state == ldp_axi_pkg::AW_FC1);

    always_comb begin
        aw = '0;
        case (state)
            ldp_axi_pkg::AW_FIRST_FD: begin
                aw.addr  = fd_addr;
                aw.len   = 8'(FD_BURST_BEATS - 1);
                // Wait until the W side has started a frame we have not yet served
                aw.valid = (frame_count > issued_frames);
            end
            ldp_axi_pkg::AW_FD: begin
                aw.addr  = fd_addr;
                aw.len   = 8'(FD_BURST_BEATS - 1);
                aw.valid = 1'b1;
            end
            ldp_axi_pkg::AW_MD0, ldp_axi_pkg::AW_MD1: begin
                aw.addr  = (state == ldp_axi_pkg::AW_MD0) ? md0_addr : md1_addr;
                aw.len   = 8'(ldp_axi_pkg::MD_BEATS - 1);
                aw.valid = 1'b1;
            end
            ldp_axi_pkg::AW_FC0, ldp_axi_pkg::AW_FC1: begin
                // Single-beat writes of the frame counter
                aw.addr  = (state == ldp_axi_pkg::AW_FC0) ? cfg.fc0_addr : cfg.fc1_addr;
                aw.valid = 1'b1;
            end
            default: begin
                aw = '0;
            end
        endcase
    end

    // ========================================
    // Request sequencing
    // ========================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state         <= ldp_axi_pkg::AW_FIRST_FD;
            issued_frames <= 32'd0;
            burst_cnt     <= 32'd0;
        end else if (aw_xfer) begin
            case (state)
                ldp_axi_pkg::AW_FIRST_FD: begin
                    issued_frames <= issued_frames + 32'd1;
                    burst_cnt     <= 32'd1;
                    state         <= (cfg.frame_bursts == 32'd1) ?
                                     ldp_axi_pkg::AW_MD0 : ldp_axi_pkg::AW_FD;
                end
                ldp_axi_pkg::AW_FD: begin
                    burst_cnt <= burst_cnt + 32'd1;
                    if (burst_cnt + 32'd1 == cfg.frame_bursts) begin
                        state <= ldp_axi_pkg::AW_MD0;
                    end
                end
                ldp_axi_pkg::AW_MD0: state <= ldp_axi_pkg::AW_MD1;
                ldp_axi_pkg::AW_MD1: state <= ldp_axi_pkg::AW_FC0;
                ldp_axi_pkg::AW_FC0: state <= ldp_axi_pkg::AW_FC1;
                default:             state <= ldp_axi_pkg::AW_FIRST_FD;
            endcase
        end
    end

    // A stalled request keeps its address until the slave takes it
    assert property (@(posedge clk) disable iff (!resetn)
        aw.valid && !aw_ready |=> $stable(aw.addr))
        else $error("aw.addr changed while waiting for aw_ready");

endmodule

`default_nettype wire

// File: src/ldp_addr_gen.sv
// Host address pointers for the frame writer
// Ping-pongs frame data between two rings and walks the shared metadata offset

`timescale 1ns/1ps
`default_nettype none

module ldp_addr_gen #(
    parameter int DATA_W           = 512,
    parameter int FD_BURST_BEATS   = 64,
    parameter int BURSTS_PER_GROUP = 4
) (
    input  wire                             clk,
    input  wire                             resetn,
    input  wire ldp_cfg_pkg::ldp_cfg_t      cfg,
    input  wire                             fd_adv,
    input  wire                             md_adv,
    output ldp_cfg_pkg::host_addr_t         fd_addr,
    output ldp_cfg_pkg::host_addr_t         md0_addr,
    output ldp_cfg_pkg::host_addr_t         md1_addr
);

    // Bytes moved by one burst of each kind
    localparam ldp_cfg_pkg::host_addr_t FD_BURST_BYTES = FD_BURST_BEATS * (DATA_W / 8);
    localparam ldp_cfg_pkg::host_addr_t MD_BURST_BYTES = ldp_axi_pkg::MD_BEATS * (DATA_W / 8);

    ldp_cfg_pkg::host_addr_t fd0_off;
    ldp_cfg_pkg::host_addr_t fd1_off;
    ldp_cfg_pkg::host_addr_t md_off;

    // Runs 1 to 2*BURSTS_PER_GROUP, the upper half selects ring 1
    logic [15:0] grp_cnt;
    logic        group_sel;

    // Step an offset by one burst, wrapping to zero at the ring size
    function automatic ldp_cfg_pkg::host_addr_t next_off(
        input ldp_cfg_pkg::host_addr_t off,
        input ldp_cfg_pkg::host_addr_t step,
        input ldp_cfg_pkg::host_addr_t size
    );
        ldp_cfg_pkg::host_addr_t sum;
        sum = off + step;
        return (sum >= size) ? '0 : sum;
    endfunction

    assign group_sel = (grp_cnt > BURSTS_PER_GROUP);

    assign fd_addr  = group_sel ? cfg.fd1_base + fd1_off : cfg.fd0_base + fd0_off;
    assign md0_addr = cfg.md0_base + md_off;
    assign md1_addr = cfg.md1_base + md_off;

    // ========================================
    // Frame-data pointers
    // ========================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            fd0_off <= '0;
            fd1_off <= '0;
            grp_cnt <= 16'd1;
        end else if (fd_adv) begin
            // Only the ring that took this burst moves on
            if (group_sel) begin
                fd1_off <= next_off(fd1_off, FD_BURST_BYTES, cfg.fd_ring_size);
            end else begin
                fd0_off <= next_off(fd0_off, FD_BURST_BYTES, cfg.fd_ring_size);
            end
            if (grp_cnt == 16'(2 * BURSTS_PER_GROUP)) begin
                grp_cnt <= 16'd1;
            end else begin
                grp_cnt <= grp_cnt + 16'd1;
            end
        end
    end

    // Metadata offset moves once per frame, after the last counter request
    always_ff @(posedge clk) begin
        if (!resetn) begin
            md_off <= '0;
        end else if (md_adv) begin
            md_off <= next_off(md_off, MD_BURST_BYTES, cfg.md_ring_size);
        end
    end

endmodule

`default_nettype wire

// File: src/ldp_md_capture.sv
// Metadata capture for the frame writer
// Arms on each frame's first data transfer and stores the two metadata beats

`timescale 1ns/1ps
`default_nettype none

module ldp_md_capture #(
    parameter int DATA_W = 512
) (
    input  wire                clk,
    input  wire                resetn,
    input  wire                frame_start,
    input  wire  [DATA_W-1:0]  md_tdata,
    input  wire                md_tvalid,
    output logic               md_tready,
    output logic [ldp_axi_pkg::MD_BEATS-1:0][DATA_W-1:0] md_words
);

    // Zero while idle, otherwise the 1-based metadata beat being waited for
    logic [1:0] cap_cnt;
    logic       md_xfer;

    assign md_tready = (cap_cnt != 2'd0);
    assign md_xfer   = md_tvalid & md_tready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cap_cnt <= 2'd0;
        end else if (cap_cnt == 2'd0) begin
            if (frame_start) begin
                cap_cnt <= 2'd1;
            end
        end else if (md_xfer) begin
            // Return to idle once the last beat is in
            if (cap_cnt == 2'(ldp_axi_pkg::MD_BEATS)) begin
                cap_cnt <= 2'd0;
            end else begin
                cap_cnt <= cap_cnt + 2'd1;
            end
        end
    end

    // Beats land in arrival order and stay put between frames
    always_ff @(posedge clk) begin
        if (md_xfer) begin
            md_words[cap_cnt - 2'd1] <= md_tdata;
        end
    end

    // Upstream must finish a frame's metadata before the next frame begins
    assert property (@(posedge clk) disable iff (!resetn) frame_start |-> cap_cnt == 2'd0)
        else $error("frame_start arrived during an unfinished metadata capture");

endmodule

`default_nettype wire

// File: src/ldp_axi_pkg.sv
// AXI4 write-channel types and sequencer states for the frame writer
// The W beat is sized for the widest bus, narrower builds use the low bits

`default_nettype none

package ldp_axi_pkg;

    // Widest supported data bus
    localparam int MAX_DATA_W = 512;

    // Metadata beats captured and written per frame
    localparam int MD_BEATS = 2;

    // Write-address request, full-width incrementing burst assumed
    typedef struct packed {
        ldp_cfg_pkg::host_addr_t addr;
        // Beats in the burst minus one
        logic [7:0]              len;
        logic                    valid;
    } aw_req_t;

    // One write-data beat
    typedef struct packed {
        logic [MAX_DATA_W-1:0]   data;
        logic [MAX_DATA_W/8-1:0] strb;
        logic                    last;
        logic                    valid;
    } w_beat_t;

    // Walked once per frame by the AW sequencer
    typedef enum logic [2:0] {
        AW_FIRST_FD,
        AW_FD,
        AW_MD0,
        AW_MD1,
        AW_FC0,
        AW_FC1
    } aw_state_t;

    // Walked once per frame by the W sequencer
    typedef enum logic [2:0] {
        W_FIRST_FD,
        W_FD,
        W_MD00,
        W_MD01,
        W_MD10,
        W_MD11,
        W_FC0,
        W_FC1
    } w_state_t;

endpackage

`default_nettype wire

// File: src/ldp_cfg_pkg.sv
// Run-time configuration of the host-RAM frame writer
// Software programs the buffer layout here before it releases reset

`default_nettype none

package ldp_cfg_pkg;

    // A host byte address, or a byte size within host memory
    typedef logic [63:0] host_addr_t;

    // Buffer layout in host RAM, held static while resetn is high
    typedef struct packed {
        // Number of frame-data bursts that make up one frame
        logic [31:0] frame_bursts;
        // Both frame-data rings share one size
        host_addr_t  fd0_base;
        host_addr_t  fd1_base;
        host_addr_t  fd_ring_size;
        // The metadata rings receive identical copies at the same offset
        host_addr_t  md0_base;
        host_addr_t  md1_base;
        host_addr_t  md_ring_size;
        // Each frame ends with its count written to both of these
        host_addr_t  fc0_addr;
        host_addr_t  fc1_addr;
    } ldp_cfg_t;

endpackage

`default_nettype wire
